/* request_queue_bank.f */
queue_pkg.sv
fifo.sv
request_steer.sv
bus_cycle_sequencer.sv
request_queue_bank.sv
tb_request_queue_bank.sv

/* Bender.yml */
package:
  name: request_queue_bank

sources:
  - queue_pkg.sv
  - fifo.sv
  - request_steer.sv
  - bus_cycle_sequencer.sv
  - request_queue_bank.sv
  - target: test
    files:
      - tb_request_queue_bank.sv

/* tb_request_queue_bank.sv */
`timescale 1ns/100ps

module tb_request_queue_bank;

    import queue_pkg::*;

    // About 400 cycles of tests at four clocks per issue, plus margin
    localparam int max_cycles = 600;

    logic clk;
    logic reset;
    logic in_valid;
    bus_op_t in_op;
    logic [payload_width-1:0] in_payload;
    logic [num_queues-1:0] full;
    logic [num_queues-1:0] nearly_full;
    logic [bad_count_width-1:0] bad_op_count;
    logic out_valid;
    bus_op_t out_op;
    logic [payload_width-1:0] out_payload;

    // Reference queue per class, capped at queue_depth
    logic [payload_width-1:0] model_mem [num_queues][queue_depth];
    int model_head [num_queues];
    int model_cnt [num_queues];
    int model_rr;
    // Requests between the input pins and the queue write edge
    logic stage1_valid;
    logic stage2_valid;
    int stage1_op;
    int stage2_op;
    logic [payload_width-1:0] stage1_data;
    logic [payload_width-1:0] stage2_data;
    logic [num_queues-1:0] prev_full;
    logic [num_queues-1:0] prev_nearly_full;
    // Queues whose full flag has been seen high
    logic [num_queues-1:0] full_seen;

    integer seed;
    int cycles;
    int out_count;
    int last_out_cycle;
    int errors;
    int err_mark;
    int tests_run;
    int tests_failed;
    string test_name;

    request_queue_bank dut0 (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_op(in_op),
        .in_payload(in_payload),
        .full(full),
        .nearly_full(nearly_full),
        .bad_op_count(bad_op_count),
        .out_valid(out_valid),
        .out_op(out_op),
        .out_payload(out_payload)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog on the cycle count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic flag_mismatch(input string what, input longint expected, input longint actual);
        $display("CHECK FAILED %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("ERROR %s: %s", test_name, what);
        errors++;
    endtask

    // Monitor runs on the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        int q;
        int slot;
        logic exp_full;
        logic exp_nearly;
        logic [num_queues-1:0] was_full;
        if (reset) begin
            for (int k = 0; k < num_queues; k++) begin
                model_head[k] = 0;
                model_cnt[k] = 0;
            end
            model_rr = 0;
            stage1_valid = 1'b0;
            stage2_valid = 1'b0;
            prev_full = '0;
            prev_nearly_full = '0;
        end else begin
            // Flags from the last cycle against the occupancy they describe
            for (int k = 0; k < num_queues; k++) begin
                exp_full = model_cnt[k] == queue_depth;
                exp_nearly = model_cnt[k] >= queue_depth - queue_free_threshold;
                was_full[k] = exp_full;
                assert (prev_full[k] == exp_full)
                    else flag_mismatch("full flag", exp_full, prev_full[k]);
                assert (prev_nearly_full[k] == exp_nearly)
                    else flag_mismatch("nearly_full flag", exp_nearly, prev_nearly_full[k]);
            end
            // An issue seen now was popped at the previous edge
            if (out_valid) begin
                q = -1;
                for (int k = 0; k < num_queues; k++) begin
                    slot = (model_rr + k) % num_queues;
                    if (q < 0 && model_cnt[slot] != 0) begin
                        q = slot;
                    end
                end
                if (q < 0) begin
                    report_fault("output issued while every reference queue was empty");
                end else begin
                    assert (out_op == bus_op_t'(q))
                        else flag_mismatch("out_op", q, int'(out_op));
                    assert (out_payload == model_mem[q][model_head[q]])
                        else flag_mismatch("out_payload", model_mem[q][model_head[q]], out_payload);
                    model_head[q] = (model_head[q] + 1) % queue_depth;
                    model_cnt[q]--;
                    model_rr = (q + 1) % num_queues;
                end
                assert (cycles - last_out_cycle >= bus_cycle_len)
                    else flag_mismatch("issue spacing", bus_cycle_len, cycles - last_out_cycle);
                last_out_cycle = cycles;
                out_count++;
            end
            // Queue write of a legal request, lost when its class was full before the edge
            if (stage2_valid && stage2_op < num_queues && !was_full[stage2_op]) begin
                slot = (model_head[stage2_op] + model_cnt[stage2_op]) % queue_depth;
                model_mem[stage2_op][slot] = stage2_data;
                model_cnt[stage2_op]++;
            end
            stage2_valid = stage1_valid;
            stage2_op = stage1_op;
            stage2_data = stage1_data;
            stage1_valid = in_valid;
            stage1_op = int'(in_op);
            stage1_data = in_payload;
            prev_full = full;
            prev_nearly_full = nearly_full;
            full_seen = full_seen | full;
        end
    end

    task automatic send_request(input int op, input logic [payload_width-1:0] data);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_op = bus_op_t'(op[2:0]);
        in_payload = data;
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_op = op_mem_read;
        in_payload = '0;
    endtask

    // Wait until every request has left, then let the sequencer go idle
    task automatic drain();
        int pending;
        pending = 1;
        while (pending != 0) begin
            @(posedge clk);
            pending = int'(stage1_valid) + int'(stage2_valid);
            for (int k = 0; k < num_queues; k++) begin
                pending += model_cnt[k];
            end
        end
        repeat (bus_cycle_len + 1) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > err_mark) begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - err_mark);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    initial begin
        int sample_cycle;
        int count_before;
        logic [bad_count_width-1:0] bad_before;
        seed = 32'h34f1fac7;
        cycles = 0;
        out_count = 0;
        last_out_cycle = -100;
        errors = 0;
        full_seen = '0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "setup";
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = op_mem_read;
        in_payload = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("reset_state");
        @(negedge clk);
        assert (out_valid == 1'b0) else flag_mismatch("out_valid", 0, out_valid);
        assert (full == '0) else flag_mismatch("full", 0, full);
        assert (nearly_full == '0) else flag_mismatch("nearly_full", 0, nearly_full);
        assert (bad_op_count == '0) else flag_mismatch("bad_op_count", 0, bad_op_count);
        end_test();

        // Idle sequencer and empty queues, so exactly two clocks
        start_test("single_latency");
        send_request(1, 32'h1234_abcd);
        sample_cycle = cycles + 1;
        count_before = out_count;
        idle_inputs();
        while (out_count == count_before) begin
            @(posedge clk);
        end
        assert (last_out_cycle - sample_cycle == 2)
            else flag_mismatch("latency", 2, last_out_cycle - sample_cycle);
        drain();
        end_test();

        start_test("fifo_order");
        for (int n = 0; n < 12; n++) begin
            send_request($random(seed) & 3, $random(seed));
        end
        idle_inputs();
        drain();
        end_test();

        start_test("round_robin");
        for (int r = 0; r < 3; r++) begin
            for (int q = 0; q < num_queues; q++) begin
                send_request(q, $random(seed));
            end
        end
        idle_inputs();
        drain();
        end_test();

        // Queues 0 to 2 keep the sequencer busy while queue 3 overflows
        start_test("flags_overflow");
        full_seen = '0;
        for (int r = 0; r < 3; r++) begin
            for (int q = 0; q < 3; q++) begin
                send_request(q, $random(seed));
            end
        end
        for (int n = 0; n < 8; n++) begin
            send_request(int'(op_io_write), $random(seed));
        end
        idle_inputs();
        drain();
        assert (full_seen[int'(op_io_write)])
            else report_fault("queue 3 never reported full during the burst");
        end_test();

        start_test("bad_opcodes");
        @(negedge clk);
        bad_before = bad_op_count;
        @(posedge clk);
        count_before = out_count;
        for (int n = 4; n < 8; n++) begin
            send_request(n, $random(seed));
        end
        idle_inputs();
        repeat (2 * bus_cycle_len) @(posedge clk);
        assert (out_count == count_before)
            else flag_mismatch("issued requests", count_before, out_count);
        @(negedge clk);
        assert (bad_op_count == bad_before + 4)
            else flag_mismatch("bad_op_count", bad_before + 4, bad_op_count);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* request_queue_bank.sv */
`timescale 1ns/100ps

module request_queue_bank (
    input  logic clk,
    input  logic reset,
    // Requester side
    input  logic in_valid,
    input  queue_pkg::bus_op_t in_op,
    input  logic [queue_pkg::payload_width-1:0] in_payload,
    output logic [queue_pkg::num_queues-1:0] full,
    output logic [queue_pkg::num_queues-1:0] nearly_full,
    output logic [queue_pkg::bad_count_width-1:0] bad_op_count,
    // Bus side
    output logic out_valid,
    output queue_pkg::bus_op_t out_op,
    output logic [queue_pkg::payload_width-1:0] out_payload
);

    import queue_pkg::*;

    logic [num_queues-1:0] wr_en;
    logic [payload_width-1:0] wr_data;
    logic [num_queues-1:0] rd_en;
    logic [num_queues-1:0] empty;
    logic [num_queues-1:0][payload_width-1:0] rd_data;

    // Register and decode incoming requests
    request_steer steer0 (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_op(in_op),
        .in_payload(in_payload),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .bad_op_count(bad_op_count)
    );

    // One queue per request class
    for (genvar i = 0; i < num_queues; i++) begin : queue_gen
        fifo #(
            .data_width(payload_width),
            .depth(queue_depth),
            .full_threshold(queue_free_threshold)
        ) queue0 (
            .clk(clk),
            .reset(reset),
            .wr_en(wr_en[i]),
            .wr_data(wr_data),
            .rd_en(rd_en[i]),
            .rd_data(rd_data[i]),
            .empty(empty[i]),
            .nearly_full(nearly_full[i]),
            .full(full[i])
        );
    end

    // Drain the queues onto the bus
    bus_cycle_sequencer seq0 (
        .clk(clk),
        .reset(reset),
        .empty(empty),
        .head_data(rd_data),
        .rd_en(rd_en),
        .out_valid(out_valid),
        .out_op(out_op),
        .out_payload(out_payload)
    );

endmodule

/* bus_cycle_sequencer.sv */
`timescale 1ns/100ps

module bus_cycle_sequencer (
    input  logic clk,
    input  logic reset,
    // Queue heads
    input  logic [queue_pkg::num_queues-1:0] empty,
    input  logic [queue_pkg::num_queues-1:0][queue_pkg::payload_width-1:0] head_data,
    output logic [queue_pkg::num_queues-1:0] rd_en,
    // Issued request
    output logic out_valid,
    output queue_pkg::bus_op_t out_op,
    output logic [queue_pkg::payload_width-1:0] out_payload
);

    import queue_pkg::*;

    localparam int cnt_bits = $clog2(bus_cycle_len + 1);

    seq_state_t state;
    logic [queue_index_width-1:0] rr_ptr;
    logic [queue_index_width-1:0] grant_idx;
    logic [queue_index_width-1:0] next_ptr;
    logic [cnt_bits-1:0] cycle_cnt;
    logic cycle_done;
    logic found;
    logic grant;

    // First non-empty queue at or after the round-robin pointer
    always_comb begin
        int idx;
        found = 1'b0;
        grant_idx = rr_ptr;
        for (int i = 0; i < num_queues; i++) begin
            idx = (int'(rr_ptr) + i) % num_queues;
            if (!found && !empty[idx]) begin
                found = 1'b1;
                grant_idx = queue_index_width'(idx);
            end
        end
    end

    // Clocks since the last issue have covered a full bus cycle
    assign cycle_done = cycle_cnt >= cnt_bits'(bus_cycle_len - 1);

    // Grant from idle, or back to back at the end of T4
    assign grant = found && (state == seq_idle || (state == seq_t4 && cycle_done));
    assign rd_en = grant ? num_queues'(1) << grant_idx : '0;

    // Pointer moves just past the granted queue
    assign next_ptr = (grant_idx == queue_index_width'(num_queues - 1)) ? '0
                                                                        : grant_idx + 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= seq_idle;
            rr_ptr <= '0;
            cycle_cnt <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= grant;
            if (grant) begin
                rr_ptr <= next_ptr;
            end
            // Count bus clocks, restarting at each issue
            if (grant) begin
                cycle_cnt <= '0;
            end else if (!cycle_done) begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
            case (state)
                seq_idle: if (grant) state <= seq_t1;
                seq_t1: state <= seq_t2;
                seq_t2: state <= seq_t3;
                seq_t3: state <= seq_t4;
                // T4 stretches until the bus cycle length is met
                seq_t4: begin
                    if (grant) begin
                        state <= seq_t1;
                    end else if (cycle_done) begin
                        state <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // Capture the popped head and its class
    always_ff @(posedge clk) begin
        if (grant) begin
            out_payload <= head_data[grant_idx];
            out_op <= bus_op_t'(op_width'(grant_idx));
        end
    end

endmodule

/* request_steer.sv */
`timescale 1ns/100ps

module request_steer (
    input  logic clk,
    input  logic reset,
    // Requester strobe
    input  logic in_valid,
    input  queue_pkg::bus_op_t in_op,
    input  logic [queue_pkg::payload_width-1:0] in_payload,
    // Queue write side
    output logic [queue_pkg::num_queues-1:0] wr_en,
    output logic [queue_pkg::payload_width-1:0] wr_data,
    // Rejected opcode tally
    output logic [queue_pkg::bad_count_width-1:0] bad_op_count
);

    import queue_pkg::*;

    logic op_legal;
    logic [num_queues-1:0] op_onehot;

    // Only the four defined codes are accepted
    always_comb begin
        case (in_op)
            op_mem_read,
            op_mem_write,
            op_io_read,
            op_io_write: op_legal = 1'b1;
            default: op_legal = 1'b0;
        endcase
    end

    // Queue index is the low bits of the opcode
    assign op_onehot = num_queues'(1) << in_op[queue_index_width-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_en <= '0;
            bad_op_count <= '0;
        end else begin
            // Single-cycle write strobe, one clock after the request
            wr_en <= (in_valid && op_legal) ? op_onehot : '0;
            // Saturate rather than wrap
            if (in_valid && !op_legal && bad_op_count != '1) begin
                bad_op_count <= bad_op_count + 1'b1;
            end
        end
    end

    // Shared write data to all queues
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wr_data <= in_payload;
        end
    end

endmodule

/* fifo.sv */
`timescale 1ns/100ps

module fifo #(
    parameter int data_width = 32,
    parameter int depth = 6,
    // Free entries at or below which nearly_full is raised
    parameter int full_threshold = 2
) (
    input  logic clk,
    input  logic reset,
    // Write side
    input  logic wr_en,
    input  logic [data_width-1:0] wr_data,
    // Read side
    input  logic rd_en,
    output logic [data_width-1:0] rd_data,
    output logic empty,
    output logic nearly_full,
    output logic full
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_bits = $clog2(depth + 1);
    localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(depth - 1);

    logic [data_width-1:0] mem [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] next_rd_ptr;
    logic [count_bits-1:0] count;
    logic wr_ok;
    logic rd_ok;

    // Ignore writes while full and pops while empty
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    assign empty = count == '0;
    assign full = count == count_bits'(depth);
    assign nearly_full = int'(count) >= depth - full_threshold;

    // Read pointer after this cycle's pop, wrapping at the last slot
    always_comb begin
        next_rd_ptr = rd_ptr;
        if (rd_ok) begin
            next_rd_ptr = (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Registered head of queue
    // Bypass the array when the slot being written is the new head
    always_ff @(posedge clk) begin
        if (wr_ok && wr_ptr == next_rd_ptr) begin
            rd_data <= wr_data;
        end else begin
            rd_data <= mem[next_rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            rd_ptr <= next_rd_ptr;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            // Occupancy holds when a write and a pop coincide
            case ({wr_ok, rd_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* queue_pkg.sv */
package queue_pkg;

    // Request opcodes, codes 4 to 7 are reserved
    // Low two bits of a legal code select its queue
    typedef enum logic [2:0] {
        op_mem_read  = 3'd0,
        op_mem_write = 3'd1,
        op_io_read   = 3'd2,
        op_io_write  = 3'd3
    } bus_op_t;

    // Bus cycle sequencer states
    typedef enum logic [2:0] {
        seq_idle,
        seq_t1,
        seq_t2,
        seq_t3,
        seq_t4
    } seq_state_t;

    // One queue per legal opcode
    localparam int num_queues = 4;
    // Address in [31:16], write data in [15:0]
    localparam int payload_width = 32;
    localparam int queue_depth = 6;
    // nearly_full once this many entries or fewer are free
    localparam int queue_free_threshold = 2;
    // Minimum clocks between two issued requests
    localparam int bus_cycle_len = 4;
    localparam int bad_count_width = 8;

    // Derived widths
    localparam int queue_index_width = $clog2(num_queues);
    localparam int op_width = $bits(bus_op_t);

endpackage
